// ==== all.f ====
rtl/decode_pkg.sv
rtl/control_unit.sv
rtl/imm_extractor.sv
rtl/decode_output_stage.sv
rtl/decode_stage.sv
bench/decode_stage_tb.sv

// ==== Makefile ====
# Verilator build for the decode stage

VERILATOR  ?= verilator
FILELIST   := all.f
TB_TOP     := decode_stage_tb
RTL_TOP    := decode_stage
OBJ_DIR    := obj_dir
COMMON     := --timing --assert --timescale 1ns/100ps
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary $(COMMON) -j 0
PASS_MSG   := RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TB_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/decode_stage_tb.sv ====
`timescale 1ns/100ps

module decode_stage_tb import decode_pkg::*; ();

   logic                  clk_i = 1'b0;
   logic                  rst_n_i;
   logic                  stall_i;
   logic                  instr_valid_i;
   logic [xlen-1:0]       instr_i;
   logic                  valid_o;
   logic [reg_addr_w-1:0] rd_addr_o;
   logic [reg_addr_w-1:0] rs1_addr_o;
   logic [reg_addr_w-1:0] rs2_addr_o;
   logic [reg_addr_w-1:0] rs3_addr_o;
   logic                  uses_rd_o;
   logic                  uses_rs1_o;
   logic                  uses_rs2_o;
   logic                  uses_rs3_o;
   logic [xlen-1:0]       imm_o;

   // every output in one word, for the reset and stall checks
   logic [56:0]           out_bus;
   logic [56:0]           out_snap = '0;
   // expected register contents after the last unstalled edge
   logic                  exp_valid = 1'b0;
   logic [3:0]            exp_uses = '0;
   logic [reg_addr_w-1:0] exp_rd = '0;
   logic [reg_addr_w-1:0] exp_rs1 = '0;
   logic [reg_addr_w-1:0] exp_rs2 = '0;
   logic [reg_addr_w-1:0] exp_rs3 = '0;
   logic [xlen-1:0]       exp_imm = '0;
   logic [3:0]            uses_next;
   // edge history for the checks
   logic                  rst_seen = 1'b0;
   logic                  in_reset_q = 1'b0;
   logic                  stalled_q = 1'b0;
   logic [15:0]           lfsr = 16'd30570;
   int                    error_count = 0;
   int                    tests_run = 0;
   int                    tests_failed = 0;

   always #2 clk_i = ~clk_i;

   decode_stage decode_stage_i (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .stall_i       (stall_i),
      .instr_valid_i (instr_valid_i),
      .instr_i       (instr_i),
      .valid_o       (valid_o),
      .rd_addr_o     (rd_addr_o),
      .rs1_addr_o    (rs1_addr_o),
      .rs2_addr_o    (rs2_addr_o),
      .rs3_addr_o    (rs3_addr_o),
      .uses_rd_o     (uses_rd_o),
      .uses_rs1_o    (uses_rs1_o),
      .uses_rs2_o    (uses_rs2_o),
      .uses_rs3_o    (uses_rs3_o),
      .imm_o         (imm_o)
   );

   assign out_bus = {valid_o, rd_addr_o, rs1_addr_o, rs2_addr_o, rs3_addr_o,
                     uses_rd_o, uses_rs1_o, uses_rs2_o, uses_rs3_o, imm_o};

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      logic fb;
      fb = s[15] ^ s[13] ^ s[12] ^ s[10];
      return {s[14:0], fb};
   endfunction

   // one lfsr step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   // table of the nineteen major opcodes
   function automatic logic [4:0] opcode_at(input int idx);
      logic [4:0] opc;
      case (idx)
         0:       opc = opc_load;
         1:       opc = opc_load_fp;
         2:       opc = opc_misc_mem;
         3:       opc = opc_op_imm;
         4:       opc = opc_auipc;
         5:       opc = opc_store;
         6:       opc = opc_store_fp;
         7:       opc = opc_amo;
         8:       opc = opc_op;
         9:       opc = opc_lui;
         10:      opc = opc_madd;
         11:      opc = opc_msub;
         12:      opc = opc_nmsub;
         13:      opc = opc_nmadd;
         14:      opc = opc_op_fp;
         15:      opc = opc_branch;
         16:      opc = opc_jalr;
         17:      opc = opc_jal;
         default: opc = opc_system;
      endcase
      return opc;
   endfunction

   // random fields around a fixed opcode, low bits 11 for 32-bit encodings
   function automatic logic [31:0] make_instr(input logic [4:0] opc);
      logic [31:0] v;
      v = rand_bits(25);
      return {v[24:0], opc, 2'b11};
   endfunction

   function automatic int source_count(input logic [4:0] opc, input logic [2:0] f3);
      int n;
      case (opc)
         opc_madd, opc_msub, opc_nmsub, opc_nmadd: n = 3;
         opc_store, opc_store_fp, opc_amo, opc_op, opc_op_fp, opc_branch: n = 2;
         opc_load, opc_load_fp, opc_misc_mem, opc_op_imm, opc_jalr: n = 1;
         // csr immediate forms read no register
         opc_system: n = f3[2] ? 0 : 1;
         default: n = 0;
      endcase
      return n;
   endfunction

   // {rd, rs1, rs2, rs3}
   function automatic logic [3:0] model_uses(input logic [31:0] instr);
      int  n;
      logic rd;
      n = source_count(instr[6:2], instr[14:12]);
      rd = !(instr[6:2] inside {opc_store, opc_store_fp, opc_branch});
      return {rd, n >= 1, n >= 2, n == 3};
   endfunction

   // fields packed to the top, then arithmetic shift for the sign
   function automatic logic [31:0] model_imm(input logic [31:0] instr);
      logic [31:0] raw;
      logic [31:0] imm;
      case (instr[6:2])
         opc_lui, opc_auipc, opc_system: imm = {instr[31:12], 12'h000};
         opc_store, opc_store_fp: begin
            raw = {instr[31:25], instr[11:7], 20'h00000};
            imm = $signed(raw) >>> 20;
         end
         opc_branch: begin
            raw = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0, 19'h00000};
            imm = $signed(raw) >>> 19;
         end
         opc_jal: begin
            raw = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0, 11'h000};
            imm = $signed(raw) >>> 11;
         end
         default: imm = $signed(instr) >>> 20;
      endcase
      return imm;
   endfunction

   assign uses_next = model_uses(instr_i);

   // reference model, follows the instruction taken at each unstalled edge
   always @(posedge clk_i) begin
      in_reset_q <= !rst_n_i;
      stalled_q  <= rst_n_i && stall_i;
      out_snap   <= out_bus;
      if (!rst_n_i) begin
         rst_seen  <= 1'b1;
         exp_valid <= 1'b0;
         exp_uses  <= '0;
         exp_rd    <= '0;
         exp_rs1   <= '0;
         exp_rs2   <= '0;
         exp_rs3   <= '0;
         exp_imm   <= '0;
      end else if (!stall_i) begin
         exp_valid <= instr_valid_i;
         exp_uses  <= uses_next;
         exp_rd    <= uses_next[3] ? instr_i[11:7] : 5'd0;
         exp_rs1   <= uses_next[2] ? instr_i[19:15] : 5'd0;
         exp_rs2   <= uses_next[1] ? instr_i[24:20] : 5'd0;
         exp_rs3   <= uses_next[0] ? instr_i[31:27] : 5'd0;
         exp_imm   <= model_imm(instr_i);
      end
   end

   reset_zero: assert property (@(posedge clk_i) disable iff (!rst_seen)
      in_reset_q |-> (out_bus == '0))
   else begin
      error_count = error_count + 1;
      $display("error at time %0t: outputs not zero in reset, got %h", $time, out_bus);
   end

   reg_use_match: assert property (@(posedge clk_i) disable iff (!rst_seen)
      {uses_rd_o, uses_rs1_o, uses_rs2_o, uses_rs3_o} == exp_uses && rd_addr_o == exp_rd
      && rs1_addr_o == exp_rs1 && rs2_addr_o == exp_rs2 && rs3_addr_o == exp_rs3)
   else begin
      error_count = error_count + 1;
      $display("error at time %0t: flags %b addr %0d %0d %0d %0d, expected %b %0d %0d %0d %0d",
               $time, {uses_rd_o, uses_rs1_o, uses_rs2_o, uses_rs3_o}, rd_addr_o,
               rs1_addr_o, rs2_addr_o, rs3_addr_o, exp_uses, exp_rd, exp_rs1, exp_rs2,
               exp_rs3);
   end

   imm_match: assert property (@(posedge clk_i) disable iff (!rst_seen)
      imm_o == exp_imm)
   else begin
      error_count = error_count + 1;
      $display("error at time %0t: imm_o %h, expected %h", $time, imm_o, exp_imm);
   end

   valid_match: assert property (@(posedge clk_i) disable iff (!rst_seen)
      valid_o == exp_valid)
   else begin
      error_count = error_count + 1;
      $display("error at time %0t: valid_o %b, expected %b", $time, valid_o, exp_valid);
   end

   // held outputs, checked without the model
   stall_hold: assert property (@(posedge clk_i) disable iff (!rst_seen)
      stalled_q |-> (out_bus == out_snap))
   else begin
      error_count = error_count + 1;
      $display("error at time %0t: outputs moved under stall, %h was %h", $time, out_bus,
               out_snap);
   end

   // drive now, then move to 1 ns past the next rising edge
   task automatic present(input logic [31:0] instr, input logic valid, input logic stall);
      instr_i       = instr;
      instr_valid_i = valid;
      stall_i       = stall;
      @(posedge clk_i);
      #1;
   endtask

   // inputs held while waiting
   task automatic wait_valid(input int limit);
      int n;
      n = 0;
      while (!valid_o && n < limit) begin
         @(posedge clk_i);
         #1;
         n++;
      end
      if (!valid_o) begin
         $display("timeout: valid_o stayed low for %0d cycles after a valid instruction", limit);
         $display("RESULT: FAIL");
         $finish;
      end
   endtask

   // idle cycles let the last checks land
   task automatic close_test(input string name, input int start_errors);
      int errs;
      present(32'h0, 1'b0, 1'b0);
      present(32'h0, 1'b0, 1'b0);
      errs = error_count - start_errors;
      tests_run++;
      if (errs != 0)
         tests_failed++;
      $display("test %s: %0d errors", name, errs);
   endtask

   initial begin
      int start;
      int idx;
      int k;
      logic [31:0] instr;

      rst_n_i       = 1'b0;
      stall_i       = 1'b0;
      instr_valid_i = 1'b0;
      instr_i       = '0;

      // reset with busy inputs, then two stalled cycles
      start = error_count;
      repeat (16) present(rand_bits(32), 1'b1, rand_bits(1) == 1);
      rst_n_i = 1'b1;
      present(rand_bits(32), 1'b1, 1'b1);
      present(rand_bits(32), 1'b1, 1'b1);
      close_test("reset", start);

      // all opcodes, funct3 bit 2 both ways
      start = error_count;
      for (int r = 0; r < 4; r++) begin
         for (int i = 0; i < 19; i++) begin
            instr = make_instr(opcode_at(i));
            instr[14] = r[0];
            present(instr, 1'b1, 1'b0);
            wait_valid(4);
         end
      end
      repeat (40) begin
         idx = rand_bits(5) % 19;
         present(make_instr(opcode_at(idx)), 1'b1, 1'b0);
         wait_valid(4);
      end
      close_test("register use", start);

      // sign bit forced both ways for each format
      start = error_count;
      for (int s = 0; s < 2; s++) begin
         for (int i = 0; i < 19; i++) begin
            instr = make_instr(opcode_at(i));
            instr[31] = s[0];
            present(instr, 1'b1, 1'b0);
            wait_valid(4);
         end
      end
      close_test("immediates", start);

      // random valid pattern with idle gaps
      start = error_count;
      repeat (60) begin
         idx = rand_bits(5) % 19;
         k = rand_bits(1);
         present(make_instr(opcode_at(idx)), k[0], 1'b0);
         if (k[0])
            wait_valid(4);
      end
      close_test("valid strobe", start);

      // stall for 1 to 8 cycles while inputs churn
      start = error_count;
      repeat (12) begin
         idx = rand_bits(5) % 19;
         present(make_instr(opcode_at(idx)), 1'b1, 1'b0);
         wait_valid(4);
         k = 1 + int'(rand_bits(3));
         repeat (k) present(rand_bits(32), rand_bits(1) == 1, 1'b1);
         idx = rand_bits(5) % 19;
         present(make_instr(opcode_at(idx)), 1'b1, 1'b0);
         wait_valid(4);
      end
      close_test("stall", start);

      $display("tests run %0d, tests with errors %0d, check errors %0d", tests_run,
               tests_failed, error_count);
      if (error_count == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== rtl/decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage import decode_pkg::*; (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  stall_i,
   input  logic                  instr_valid_i,
   input  logic [xlen-1:0]       instr_i,
   output logic                  valid_o,
   output logic [reg_addr_w-1:0] rd_addr_o,
   output logic [reg_addr_w-1:0] rs1_addr_o,
   output logic [reg_addr_w-1:0] rs2_addr_o,
   output logic [reg_addr_w-1:0] rs3_addr_o,
   output logic                  uses_rd_o,
   output logic                  uses_rs1_o,
   output logic                  uses_rs2_o,
   output logic                  uses_rs3_o,
   output logic [xlen-1:0]       imm_o
);

   // control decoder results, combinational
   logic                 uses_rd;
   logic                 uses_rs1;
   logic                 uses_rs2;
   logic                 uses_rs3;
   logic [imm_sel_w-1:0] imm_sel;
   // candidate immediates, combinational
   logic [xlen-1:0]      imm_i;
   logic [xlen-1:0]      imm_s;
   logic [xlen-1:0]      imm_b;
   logic [xlen-1:0]      imm_u;
   logic [xlen-1:0]      imm_j;

   // opcode, funct3 and funct7 fields only
   control_unit control_unit_i (
      .opcode_i   (instr_i[6:2]),
      .funct3_i   (instr_i[14:12]),
      .funct7_i   (instr_i[31:25]),
      .uses_rd_o  (uses_rd),
      .uses_rs1_o (uses_rs1),
      .uses_rs2_o (uses_rs2),
      .uses_rs3_o (uses_rs3),
      .imm_sel_o  (imm_sel)
   );

   // whole word, runs beside the control decoder
   imm_extractor imm_extractor_i (
      .instr_i (instr_i),
      .imm_i_o (imm_i),
      .imm_s_o (imm_s),
      .imm_b_o (imm_b),
      .imm_u_o (imm_u),
      .imm_j_o (imm_j)
   );

   // merge and register, one cycle latency
   decode_output_stage decode_output_stage_i (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .stall_i       (stall_i),
      .instr_valid_i (instr_valid_i),
      .instr_i       (instr_i),
      .uses_rd_i     (uses_rd),
      .uses_rs1_i    (uses_rs1),
      .uses_rs2_i    (uses_rs2),
      .uses_rs3_i    (uses_rs3),
      .imm_sel_i     (imm_sel),
      .imm_i_i       (imm_i),
      .imm_s_i       (imm_s),
      .imm_b_i       (imm_b),
      .imm_u_i       (imm_u),
      .imm_j_i       (imm_j),
      .valid_o       (valid_o),
      .rd_addr_o     (rd_addr_o),
      .rs1_addr_o    (rs1_addr_o),
      .rs2_addr_o    (rs2_addr_o),
      .rs3_addr_o    (rs3_addr_o),
      .uses_rd_o     (uses_rd_o),
      .uses_rs1_o    (uses_rs1_o),
      .uses_rs2_o    (uses_rs2_o),
      .uses_rs3_o    (uses_rs3_o),
      .imm_o         (imm_o)
   );

endmodule

// ==== rtl/decode_output_stage.sv ====
`timescale 1ns/100ps

module decode_output_stage import decode_pkg::*; (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  stall_i,
   input  logic                  instr_valid_i,
   input  logic [xlen-1:0]       instr_i,
   // from control_unit
   input  logic                  uses_rd_i,
   input  logic                  uses_rs1_i,
   input  logic                  uses_rs2_i,
   input  logic                  uses_rs3_i,
   input  logic [imm_sel_w-1:0]  imm_sel_i,
   // from imm_extractor
   input  logic [xlen-1:0]       imm_i_i,
   input  logic [xlen-1:0]       imm_s_i,
   input  logic [xlen-1:0]       imm_b_i,
   input  logic [xlen-1:0]       imm_u_i,
   input  logic [xlen-1:0]       imm_j_i,
   // registered decode result
   output logic                  valid_o,
   output logic [reg_addr_w-1:0] rd_addr_o,
   output logic [reg_addr_w-1:0] rs1_addr_o,
   output logic [reg_addr_w-1:0] rs2_addr_o,
   output logic [reg_addr_w-1:0] rs3_addr_o,
   output logic                  uses_rd_o,
   output logic                  uses_rs1_o,
   output logic                  uses_rs2_o,
   output logic                  uses_rs3_o,
   output logic [xlen-1:0]       imm_o
);

   // next-state values for the output register
   logic [reg_addr_w-1:0] rd_addr_d;
   logic [reg_addr_w-1:0] rs1_addr_d;
   logic [reg_addr_w-1:0] rs2_addr_d;
   logic [reg_addr_w-1:0] rs3_addr_d;
   logic [xlen-1:0]       imm_d;

   // unused registers read as x0
   // keeps hazard checks downstream from seeing fake deps
   assign rd_addr_d  = uses_rd_i  ? instr_i[11:7]  : '0;
   assign rs1_addr_d = uses_rs1_i ? instr_i[19:15] : '0;
   assign rs2_addr_d = uses_rs2_i ? instr_i[24:20] : '0;
   // rs3 lives in the funct5 slot of the fma formats
   assign rs3_addr_d = uses_rs3_i ? instr_i[31:27] : '0;

   // immediate pick
   always_comb begin
      case (imm_sel_i)
         imm_sel_u_fmt: imm_d = imm_u_i;
         imm_sel_s_fmt: imm_d = imm_s_i;
         imm_sel_j_fmt: imm_d = imm_j_i;
         imm_sel_b_fmt: imm_d = imm_b_i;
         // 000 and the jalr code 100 both end up here
         default:       imm_d = imm_i_i;
      endcase
   end

   // output register
   // stall freezes everything, valid included
   // data loads on idle cycles too, valid_o qualifies it
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         valid_o    <= 1'b0;
         rd_addr_o  <= '0;
         rs1_addr_o <= '0;
         rs2_addr_o <= '0;
         rs3_addr_o <= '0;
         uses_rd_o  <= 1'b0;
         uses_rs1_o <= 1'b0;
         uses_rs2_o <= 1'b0;
         uses_rs3_o <= 1'b0;
         imm_o      <= '0;
      end else if (!stall_i) begin
         valid_o    <= instr_valid_i;
         rd_addr_o  <= rd_addr_d;
         rs1_addr_o <= rs1_addr_d;
         rs2_addr_o <= rs2_addr_d;
         rs3_addr_o <= rs3_addr_d;
         // flags pass through unchanged
         uses_rd_o  <= uses_rd_i;
         uses_rs1_o <= uses_rs1_i;
         uses_rs2_o <= uses_rs2_i;
         uses_rs3_o <= uses_rs3_i;
         imm_o      <= imm_d;
      end
   end

endmodule

// ==== rtl/imm_extractor.sv ====
`timescale 1ns/100ps

module imm_extractor import decode_pkg::*; (
   input  logic [xlen-1:0] instr_i,
   output logic [xlen-1:0] imm_i_o,
   output logic [xlen-1:0] imm_s_o,
   output logic [xlen-1:0] imm_b_o,
   output logic [xlen-1:0] imm_u_o,
   output logic [xlen-1:0] imm_j_o
);

   // sign bit sits at instr[31] for every format
   logic sign;

   assign sign = instr_i[31];

   // all five built in parallel, opcode not needed
   // the output stage picks one by imm_sel

   // I: loads, op_imm, jalr
   // 12 bits straight from the top
   assign imm_i_o = {{(xlen-12){sign}}, instr_i[31:20]};

   // S: stores
   // upper 7 from funct7 slot, lower 5 from rd slot
   assign imm_s_o = {{(xlen-12){sign}}, instr_i[31:25], instr_i[11:7]};

   // B: branches, S layout with shuffled ends
   // bit 11 comes from instr[7], lsb always zero
   assign imm_b_o = {{(xlen-13){sign}},
                     instr_i[31],
                     instr_i[7],
                     instr_i[30:25],
                     instr_i[11:8],
                     1'b0};

   // U: lui, auipc, system
   // system reads csr addr and zimm out of this later
   assign imm_u_o = {instr_i[31:12], 12'b0};

   // J: jal, U layout with shuffled fields
   // 20 bit offset in halfwords
   assign imm_j_o = {{(xlen-21){sign}},
                     instr_i[31],
                     instr_i[19:12],
                     instr_i[20],
                     instr_i[30:21],
                     1'b0};

endmodule

// ==== rtl/control_unit.sv ====
`timescale 1ns/100ps

module control_unit import decode_pkg::*; (
   input  logic [6:2]           opcode_i,
   input  logic [2:0]           funct3_i,
   // kept for the alu decode that follows later
   input  logic [6:0]           funct7_i,
   output logic                 uses_rd_o,
   output logic                 uses_rs1_o,
   output logic                 uses_rs2_o,
   output logic                 uses_rs3_o,
   output logic [imm_sel_w-1:0] imm_sel_o
);

   // rd product terms
   logic       rd_p0;
   logic       rd_p1;
   // source count, 0 to 3
   logic [1:0] rs_count;
   logic       cnt0_p0;
   logic       cnt0_p1;
   logic       cnt0_p2;
   logic       cnt0_p3;
   logic       cnt1_xor;
   logic       cnt1_p0;
   logic       cnt1_p1;
   // imm_sel product terms
   logic       sel0_p0;
   logic       sel0_p1;
   logic       sel1_p0;

   // rd dropped only for store, store_fp and branch
   // those all have bits 4:3 low and bit 5 high
   assign rd_p0     = opcode_i[3] | opcode_i[4] | ~opcode_i[5];
   // jalr sneaks back in through bits 2 and 6
   assign rd_p1     = opcode_i[2] & opcode_i[6];
   assign uses_rd_o = rd_p0 | rd_p1;

   // count bit 0, odd counts (one or three sources)
   // row 00 and the fma row with bit 4 low
   assign cnt0_p0 = ~opcode_i[4] & ~opcode_i[5];
   // op_imm
   assign cnt0_p1 = ~opcode_i[2] & opcode_i[4] & ~opcode_i[5] & ~opcode_i[6];
   // jalr
   assign cnt0_p2 = opcode_i[2] & ~opcode_i[3] & opcode_i[5] & opcode_i[6];
   // csr with register operand, funct3[2] low
   assign cnt0_p3 = opcode_i[4] & opcode_i[5] & opcode_i[6] & ~funct3_i[2];
   assign rs_count[0] = cnt0_p0 | cnt0_p1 | cnt0_p2 | cnt0_p3;

   // count bit 1, two or three sources
   // rows 01 and 10, minus lui
   assign cnt1_xor = opcode_i[5] ^ opcode_i[6];
   assign cnt1_p0  = cnt1_xor & (~opcode_i[2] | ~opcode_i[4]);
   // branch
   assign cnt1_p1  = ~opcode_i[2] & ~opcode_i[3] & ~opcode_i[4] & opcode_i[5] & opcode_i[6];
   assign rs_count[1] = cnt1_p0 | cnt1_p1;

   // thermometer flags from the count
   assign uses_rs1_o = rs_count[0] | rs_count[1];
   assign uses_rs2_o = rs_count[1];
   assign uses_rs3_o = rs_count[0] & rs_count[1];

   // imm_sel[0] set for U and J
   // lui and auipc
   assign sel0_p0 = opcode_i[2] & opcode_i[4];
   // jal and system, row 11
   assign sel0_p1 = opcode_i[5] & opcode_i[6] & ((opcode_i[2] & opcode_i[3]) | opcode_i[4]);
   assign imm_sel_o[0] = sel0_p0 | sel0_p1;

   // imm_sel[1] set for S and B
   // store, store_fp, branch; jalr excluded
   assign sel1_p0 = ~opcode_i[3] & ~opcode_i[4] & opcode_i[5];
   assign imm_sel_o[1] = sel1_p0 & (~opcode_i[2] | ~opcode_i[6]);

   // shuffle bit, row 11 with bit 4 low
   // jalr gets it too and lands on 100, read as I
   assign imm_sel_o[2] = ~opcode_i[4] & opcode_i[5] & opcode_i[6];

endmodule

// ==== rtl/decode_pkg.sv ====
package decode_pkg;

   // word width for data and immediates
   localparam int xlen       = 32;
   // register file index width
   localparam int reg_addr_w = 5;
   // immediate format code width
   localparam int imm_sel_w  = 3;

   // immediate format codes
   // bit 2 is the shuffle bit
   // J is U shuffled, B is S shuffled
   // 100 shows up for jalr and reads as I
   localparam logic [imm_sel_w-1:0] imm_sel_i_fmt = 3'b000;
   localparam logic [imm_sel_w-1:0] imm_sel_u_fmt = 3'b001;
   localparam logic [imm_sel_w-1:0] imm_sel_s_fmt = 3'b010;
   localparam logic [imm_sel_w-1:0] imm_sel_j_fmt = 3'b101;
   localparam logic [imm_sel_w-1:0] imm_sel_b_fmt = 3'b110;

   // major opcodes, instr[6:2]
   // row 00
   localparam logic [4:0] opc_load     = 5'b00000;
   localparam logic [4:0] opc_load_fp  = 5'b00001;
   localparam logic [4:0] opc_misc_mem = 5'b00011;
   localparam logic [4:0] opc_op_imm   = 5'b00100;
   localparam logic [4:0] opc_auipc    = 5'b00101;
   // row 01
   localparam logic [4:0] opc_store    = 5'b01000;
   localparam logic [4:0] opc_store_fp = 5'b01001;
   localparam logic [4:0] opc_amo      = 5'b01011;
   localparam logic [4:0] opc_op       = 5'b01100;
   localparam logic [4:0] opc_lui      = 5'b01101;
   // row 10, fused multiply-add and fp ops
   localparam logic [4:0] opc_madd     = 5'b10000;
   localparam logic [4:0] opc_msub     = 5'b10001;
   localparam logic [4:0] opc_nmsub    = 5'b10010;
   localparam logic [4:0] opc_nmadd    = 5'b10011;
   localparam logic [4:0] opc_op_fp    = 5'b10100;
   // row 11, control flow and system
   localparam logic [4:0] opc_branch   = 5'b11000;
   localparam logic [4:0] opc_jalr     = 5'b11001;
   localparam logic [4:0] opc_jal      = 5'b11011;
   localparam logic [4:0] opc_system   = 5'b11100;

endpackage
